// ==== files.f ====
+incdir+logic
logic/redundant_rx_pkg.sv
logic/frame_parser.sv
logic/copy_buffer.sv
logic/copy_comparator.sv
logic/copy_set_voter.sv
logic/replay_sender.sv
logic/redundant_rx_top.sv
tests/redundant_rx_chk.sv
tests/redundant_rx_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the redundant frame receiver testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f files.f --top-module redundant_rx_tb -Mdir obj_dir -o redundant_rx_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/redundant_rx_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

grep -q "=== FAIL ===" "$log"
found=$?
if [ $found -eq 0 ]; then
	echo "testbench reported failure"
	exit 1
fi
if [ $found -gt 1 ]; then
	echo "could not read $log"
	exit 1
fi
echo "no failure found in $log"
exit 0

// ==== tests/redundant_rx_tb.sv ====
`timescale 1ns/1ps
`include "redundant_rx_macros.svh"

module redundant_rx_tb import redundant_rx_pkg::*; ();

	localparam int n_rows = 12;
	localparam int max_len = 256;
	localparam int wait_limit = 500; // cycles per wait
	localparam int drain_cycles = 8;

	logic       clk = 1'b0;
	logic       rst_n;
	logic       rx_en;
	rx_byte_t   rx_data;
	rx_byte_t   data_out;
	logic       en_out;
	logic       lost;

	// ids in send order with the first id in the top nibble
	logic [15:0] tbl_ids [n_rows];
	int          tbl_nid [n_rows];
	int          tbl_len [n_rows];
	logic [3:0]  tbl_flip [n_rows]; // bit j flips one byte of frame j
	int          tbl_chg_slot [n_rows]; // frame with a changed length or -1
	int          tbl_chg [n_rows];
	int          tbl_exp [n_rows]; // winning copy or 0 for lost

	// reference model
	rx_byte_t   mdl_mem [1:3][max_len];
	int         mdl_len [1:3];
	set_state_e mdl_state;
	int         exp_lost;
	int         exp_win;

	rx_byte_t   base_pay [max_len];
	rx_byte_t   frm_pay [max_len];
	int         frm_len;

	rx_byte_t   got_q [$]; // bytes seen with en_out high
	int         got_lost;
	int         got_bursts;
	logic       en_prev;
	int         errors;
	int         rows_run;
	int         seed;
	bit         timed_out;

	always #5 clk = ~clk;

	redundant_rx_top UUT (
		.clk      (clk),
		.rst_n    (rst_n),
		.rx_en    (rx_en),
		.rx_data  (rx_data),
		.data_out (data_out),
		.en_out   (en_out),
		.lost     (lost)
	);

	// outputs move on the rising edge
	always @(negedge clk) begin
		if (rst_n) begin
			if (en_out)
				got_q.push_back(data_out);
			if (en_out && !en_prev)
				got_bursts++;
			if (lost)
				got_lost++;
		end
		en_prev = en_out;
	end

	task automatic report_mismatch(input string name, input int exp, input int act);
		errors++;
		$display("FAILED at %0t: %s expected %0h, got %0h", $time, name, exp, act);
	endtask

	task automatic set_row(input int r, input logic [15:0] ids, input int nid, input int len,
			input logic [3:0] flip, input int chg_slot, input int chg, input int exp);
		tbl_ids[r]      = ids;
		tbl_nid[r]      = nid;
		tbl_len[r]      = len;
		tbl_flip[r]     = flip;
		tbl_chg_slot[r] = chg_slot;
		tbl_chg[r]      = chg;
		tbl_exp[r]      = exp;
	endtask

	// ====================
	// stimulus table
	// ====================
	task automatic fill_table();
		//     row ids       nid len flip     slot chg exp
		set_row(0,  16'h1230, 3, 32, 4'b0000, -1,  0,  1); // clean set
		set_row(1,  16'h1230, 3, 32, 4'b0001, -1,  0,  2); // copy 1 bad
		set_row(2,  16'h1230, 3, 32, 4'b0010, -1,  0,  1); // copy 2 bad
		set_row(3,  16'h1230, 3, 32, 4'b0100, -1,  0,  1); // copy 3 bad
		set_row(4,  16'h1230, 3, 32, 4'b0000, 2,   3,  1); // copy 3 longer
		set_row(5,  16'h1230, 3, 32, 4'b0011, -1,  0,  0);
		set_row(6,  16'h1230, 3, 32, 4'b0111, -1,  0,  0);
		set_row(7,  16'h2000, 1, 20, 4'b0000, -1,  0,  0); // starts with copy 2
		set_row(8,  16'h1300, 2, 20, 4'b0000, -1,  0,  0); // 1 then 3
		set_row(9,  16'h1230, 3, 48, 4'b0000, -1,  0,  1);
		set_row(10, 16'h1123, 4, 32, 4'b0101, -1,  0,  1); // second copy 1 replaces
		set_row(11, 16'h1230, 3, 1,  4'b0000, 2,  -1,  1); // copy 3 empty
	endtask

	task automatic build_frame(input int r, input int slot);
		int pos;
		frm_len = tbl_len[r];
		if (slot == tbl_chg_slot[r])
			frm_len = frm_len + tbl_chg[r];
		for (int i = 0; i < frm_len; i++)
			frm_pay[i] = (i < tbl_len[r]) ? base_pay[i] : rx_byte_t'($random(seed));
		if (tbl_flip[r][slot] && frm_len > 0) begin
			pos = (3 + 5 * slot) % frm_len; // distinct spot per frame
			frm_pay[pos] = frm_pay[pos] ^ 8'h5a;
		end
	endtask

	task automatic send_frame(input int id);
		for (int i = 0; i < `RX_ID_OFFSET + 1 + frm_len; i++) begin
			@(negedge clk);
			rx_en = 1'b1;
			if (i < `RX_ID_OFFSET)
				rx_data = rx_byte_t'(160 + i); // header filler
			else if (i == `RX_ID_OFFSET)
				rx_data = {4'hc, id[3:0]};
			else
				rx_data = frm_pay[i - `RX_ID_OFFSET - 1];
		end
		@(negedge clk);
		rx_en   = 1'b0;
		rx_data = '0;
		repeat (4) @(negedge clk); // gap between frames
	endtask

	// ====================
	// reference model
	// ====================
	function automatic bit same_copy(input int a, input int b);
		if (mdl_len[a] != mdl_len[b])
			return 1'b0;
		for (int i = 0; i < mdl_len[a]; i++)
			if (mdl_mem[a][i] != mdl_mem[b][i])
				return 1'b0;
		return 1'b1;
	endfunction

	task automatic model_frame(input int id);
		if (id >= 1 && id <= 3) begin
			mdl_len[id] = frm_len;
			for (int i = 0; i < frm_len; i++)
				mdl_mem[id][i] = frm_pay[i];
		end
		case (mdl_state)
			st_idle: begin
				if (id == 1)
					mdl_state = st_got1;
				else
					exp_lost++;
			end
			st_got1: begin
				if (id == 2) begin
					mdl_state = st_got2;
				end else if (id != 1) begin
					exp_lost++;
					mdl_state = st_idle;
				end
			end
			st_got2: begin
				if (id == 1) begin
					mdl_state = st_got1;
				end else if (id == 3) begin
					if (same_copy(1, 2) || same_copy(1, 3))
						exp_win = 1;
					else if (same_copy(2, 3))
						exp_win = 2;
					else
						exp_lost++;
					mdl_state = st_idle;
				end else begin
					exp_lost++;
					mdl_state = st_idle;
				end
			end
			default: mdl_state = st_idle;
		endcase
	endtask

	task automatic wait_bytes(input int n);
		int cyc;
		cyc = 0;
		while (got_q.size() < n && cyc < wait_limit) begin
			@(posedge clk);
			cyc++;
		end
		if (got_q.size() < n) begin
			$display("timeout: only %0d of %0d replay bytes arrived", got_q.size(), n);
			errors++;
			timed_out = 1'b1;
		end
	endtask

	task automatic wait_lost(input int n);
		int cyc;
		cyc = 0;
		while (got_lost < n && cyc < wait_limit) begin
			@(posedge clk);
			cyc++;
		end
		if (got_lost < n) begin
			$display("timeout: only %0d of %0d lost pulses seen", got_lost, n);
			errors++;
			timed_out = 1'b1;
		end
	endtask

	task automatic run_row(input int r);
		int id;
		int n;
		int exp_bursts;
		@(posedge clk);
		got_q.delete();
		got_lost   = 0;
		got_bursts = 0;
		exp_lost   = 0;
		exp_win    = 0;
		for (int i = 0; i < tbl_len[r]; i++)
			base_pay[i] = rx_byte_t'($random(seed));
		for (int j = 0; j < tbl_nid[r]; j++) begin
			id = int'(tbl_ids[r][15 - 4 * j -: 4]);
			build_frame(r, j);
			model_frame(id);
			send_frame(id);
		end
		n          = (exp_win != 0) ? mdl_len[exp_win] : 0;
		exp_bursts = (n > 0) ? 1 : 0;
		if (n > 0)
			wait_bytes(n);
		if (exp_lost > 0 && !timed_out)
			wait_lost(exp_lost);
		repeat (drain_cycles) @(posedge clk); // catch stray output
		if (exp_win != tbl_exp[r]) begin
			errors++;
			$display("row %0d: table expects copy %0d but the vote gives %0d", r,
				tbl_exp[r], exp_win);
		end
		if (got_lost != exp_lost)
			report_mismatch("lost pulses", exp_lost, got_lost);
		if (got_bursts != exp_bursts)
			report_mismatch("en_out bursts", exp_bursts, got_bursts);
		if (got_q.size() != n)
			report_mismatch("en_out cycles", n, got_q.size());
		for (int i = 0; i < n && i < got_q.size(); i++)
			if (got_q[i] != mdl_mem[exp_win][i])
				report_mismatch($sformatf("data_out[%0d]", i), int'(mdl_mem[exp_win][i]),
					int'(got_q[i]));
	endtask

	// ====================
	// main sequence
	// ====================
	initial begin
		seed      = 51128;
		errors    = 0;
		rows_run  = 0;
		timed_out = 1'b0;
		rst_n     = 1'b0;
		rx_en     = 1'b0;
		rx_data   = '0;
		en_prev   = 1'b0;
		mdl_state = st_idle;
		fill_table();
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		if (en_out !== 1'b0)
			report_mismatch("en_out", 0, int'(en_out));
		if (lost !== 1'b0)
			report_mismatch("lost", 0, int'(lost));
		if (UUT.u_voter.state != st_idle) begin
			errors++;
			$display("voter is not idle after reset");
		end
		for (int r = 0; r < n_rows && !timed_out; r++) begin
			run_row(r);
			rows_run++;
		end
		$display("rows run: %0d, errors: %0d", rows_run, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// ==== tests/redundant_rx_chk.sv ====
`timescale 1ns/1ps

module redundant_rx_chk import redundant_rx_pkg::*; (
	input logic     clk,
	input logic     rst_n,
	input logic     en_out,
	input logic     lost,
	input rx_byte_t data_out
);

	logic replay_seen; // a burst went out since reset

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			replay_seen <= 1'b0;
		else if (en_out)
			replay_seen <= 1'b1;
	end

	// ====================
	// output rules
	// ====================
	a_out_excl: assert property (@(posedge clk) disable iff (!rst_n) !(en_out && lost))
		else $error("en_out and lost high in the same cycle");

	a_lost_pulse: assert property (@(posedge clk) disable iff (!rst_n) lost |=> !lost)
		else $error("lost high for more than one cycle");

	a_rst_quiet: assert property (@(posedge clk) !rst_n |-> !en_out)
		else $error("en_out high during reset");

	a_data_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(replay_seen && !en_out) |-> $stable(data_out))
		else $error("data_out moved while en_out was low");

endmodule

bind redundant_rx_top redundant_rx_chk u_chk (
	.clk      (clk),
	.rst_n    (rst_n),
	.en_out   (en_out),
	.lost     (lost),
	.data_out (data_out)
);

// ==== logic/redundant_rx_top.sv ====
`timescale 1ns/1ps
`include "redundant_rx_macros.svh"

module redundant_rx_top import redundant_rx_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     rx_en,
	input  rx_byte_t rx_data,
	output rx_byte_t data_out,
	output logic     en_out,
	output logic     lost
);

	logic        pay_wr_en;
	rx_addr_t    pay_addr;
	rx_byte_t    pay_byte;
	copy_id_t    pay_copy;
	rx_addr_t    cmp_rd_addr;
	logic        frame_done;
	copy_id_t    frame_id;
	rx_addr_t    frame_len;
	pair_agree_t agree;
	rx_addr_t    copy_len1;
	rx_addr_t    copy_len2;
	rx_addr_t    copy_len3;
	logic        replay_start;
	copy_sel_t   winner;
	rx_addr_t    replay_rd_addr;
	rx_byte_t    cmp_rd_data [`RX_COPIES];
	rx_byte_t    replay_rd_data [`RX_COPIES];

	frame_parser u_parser (
		.clk         (clk),
		.rst_n       (rst_n),
		.rx_en       (rx_en),
		.rx_data     (rx_data),
		.pay_wr_en   (pay_wr_en),
		.pay_addr    (pay_addr),
		.pay_byte    (pay_byte),
		.pay_copy    (pay_copy),
		.cmp_rd_addr (cmp_rd_addr),
		.frame_done  (frame_done),
		.frame_id    (frame_id),
		.frame_len   (frame_len)
	);

	// ====================
	// one buffer per copy
	// ====================
	for (genvar i = 0; i < `RX_COPIES; i++) begin : g_buf
		logic buf_wr_en;
		assign buf_wr_en = pay_wr_en && (pay_copy == copy_id_t'(i + 1)); // own copy only

		copy_buffer u_buf (
			.clk       (clk),
			.wr_en     (buf_wr_en),
			.wr_addr   (pay_addr),
			.wr_data   (pay_byte),
			.rd_addr_a (cmp_rd_addr),
			.rd_addr_b (replay_rd_addr),
			.rd_data_a (cmp_rd_data[i]),
			.rd_data_b (replay_rd_data[i])
		);
	end

	copy_comparator u_cmp (
		.clk          (clk),
		.rst_n        (rst_n),
		.pay_wr_en    (pay_wr_en),
		.pay_copy     (pay_copy),
		.pay_byte     (pay_byte),
		.frame_done   (frame_done),
		.frame_id     (frame_id),
		.frame_len    (frame_len),
		.cmp_rd_data1 (cmp_rd_data[0]),
		.cmp_rd_data2 (cmp_rd_data[1]),
		.cmp_rd_data3 (cmp_rd_data[2]),
		.agree        (agree),
		.copy_len1    (copy_len1),
		.copy_len2    (copy_len2),
		.copy_len3    (copy_len3)
	);

	copy_set_voter u_voter (
		.clk          (clk),
		.rst_n        (rst_n),
		.frame_done   (frame_done),
		.frame_id     (frame_id),
		.agree        (agree),
		.replay_start (replay_start),
		.winner       (winner),
		.lost         (lost)
	);

	replay_sender u_sender (
		.clk             (clk),
		.rst_n           (rst_n),
		.replay_start    (replay_start),
		.winner          (winner),
		.copy_len1       (copy_len1),
		.copy_len2       (copy_len2),
		.copy_len3       (copy_len3),
		.replay_rd_data1 (replay_rd_data[0]),
		.replay_rd_data2 (replay_rd_data[1]),
		.replay_rd_data3 (replay_rd_data[2]),
		.replay_rd_addr  (replay_rd_addr),
		.data_out        (data_out),
		.en_out          (en_out)
	);

endmodule

// ==== logic/replay_sender.sv ====
`timescale 1ns/1ps

module replay_sender import redundant_rx_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      replay_start,
	input  copy_sel_t winner,
	input  rx_addr_t  copy_len1,
	input  rx_addr_t  copy_len2,
	input  rx_addr_t  copy_len3,
	input  rx_byte_t  replay_rd_data1,
	input  rx_byte_t  replay_rd_data2,
	input  rx_byte_t  replay_rd_data3,
	output rx_addr_t  replay_rd_addr,
	output rx_byte_t  data_out,
	output logic      en_out
);

	copy_sel_t win_q; // latched winner
	rx_addr_t  len_q; // latched payload length
	rx_addr_t  start_len;
	logic      active; // address stepping
	logic      rd_valid; // read data on the bus this cycle
	rx_byte_t  sel_byte;
	rx_byte_t  hold_q; // last byte sent

	// length of the copy that won
	always_comb begin
		case (winner)
			copy_sel_t'(2): start_len = copy_len2;
			copy_sel_t'(3): start_len = copy_len3;
			default:        start_len = copy_len1;
		endcase
	end

	// read data of the latched winner
	always_comb begin
		case (win_q)
			copy_sel_t'(2): sel_byte = replay_rd_data2;
			copy_sel_t'(3): sel_byte = replay_rd_data3;
			default:        sel_byte = replay_rd_data1;
		endcase
	end

	assign en_out   = rd_valid;
	assign data_out = rd_valid ? sel_byte : hold_q; // holds between bursts

	// ====================
	// address stepping
	// ====================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			win_q          <= '0;
			len_q          <= '0;
			active         <= 1'b0;
			rd_valid       <= 1'b0;
			replay_rd_addr <= '0;
			hold_q         <= '0;
		end else begin
			if (replay_start) begin
				win_q          <= winner;
				len_q          <= start_len;
				active         <= (start_len != '0); // empty payload sends nothing
				replay_rd_addr <= '0;
			end else if (active) begin
				if (replay_rd_addr == len_q - 1'b1)
					active <= 1'b0;
				else
					replay_rd_addr <= replay_rd_addr + 1'b1;
			end
			rd_valid <= active; // one cycle of ram latency
			if (rd_valid)
				hold_q <= sel_byte;
		end
	end

endmodule

// ==== logic/copy_set_voter.sv ====
`timescale 1ns/1ps

module copy_set_voter import redundant_rx_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        frame_done,
	input  copy_id_t    frame_id,
	input  pair_agree_t agree,
	output logic        replay_start,
	output copy_sel_t   winner,
	output logic        lost
);

	set_state_e state;

	// ====================
	// order tracking and vote
	// ====================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state        <= st_idle;
			replay_start <= 1'b0;
			winner       <= '0;
			lost         <= 1'b0;
		end else begin
			replay_start <= 1'b0; // pulses
			lost         <= 1'b0;
			case (state)
				st_idle: if (frame_done) begin
					if (frame_id == copy_id_t'(1))
						state <= st_got1;
					else
						lost <= 1'b1; // set did not start with copy 1
				end
				st_got1: if (frame_done) begin
					if (frame_id == copy_id_t'(1)) begin
						state <= st_got1; // newer copy 1 took over the buffer
					end else if (frame_id == copy_id_t'(2)) begin
						state <= st_got2;
					end else begin
						lost  <= 1'b1;
						state <= st_idle;
					end
				end
				st_got2: if (frame_done) begin
					if (frame_id == copy_id_t'(1)) begin
						state <= st_got1; // restart the set
					end else if (frame_id == copy_id_t'(3)) begin
						state <= st_vote;
					end else begin
						lost  <= 1'b1;
						state <= st_idle;
					end
				end
				st_vote: begin
					// agree settled on the copy 3 frame_done edge
					state <= st_idle;
					if (agree[0] || agree[1]) begin
						winner       <= copy_sel_t'(1);
						replay_start <= 1'b1;
					end else if (agree[2]) begin
						winner       <= copy_sel_t'(2);
						replay_start <= 1'b1;
					end else begin
						lost <= 1'b1; // no two copies match
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

// ==== logic/copy_comparator.sv ====
`timescale 1ns/1ps

module copy_comparator import redundant_rx_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        pay_wr_en,
	input  copy_id_t    pay_copy,
	input  rx_byte_t    pay_byte,
	input  logic        frame_done,
	input  copy_id_t    frame_id,
	input  rx_addr_t    frame_len,
	input  rx_byte_t    cmp_rd_data1,
	input  rx_byte_t    cmp_rd_data2,
	input  rx_byte_t    cmp_rd_data3,
	output pair_agree_t agree,
	output rx_addr_t    copy_len1,
	output rx_addr_t    copy_len2,
	output rx_addr_t    copy_len3
);

	logic        writing; // a copy has started writing
	pair_agree_t base; // preset at the start of a copy
	pair_agree_t wr_hit;
	pair_agree_t done_hit;
	rx_byte_t    other_byte [3]; // the other copy of each pair
	rx_addr_t    other_len [3];

	assign base = writing ? agree : '1;

	// pair p covers one of 1/2, 1/3, 2/3
	always_comb begin
		wr_hit[0]     = (pay_copy == copy_id_t'(1)) || (pay_copy == copy_id_t'(2));
		wr_hit[1]     = (pay_copy == copy_id_t'(1)) || (pay_copy == copy_id_t'(3));
		wr_hit[2]     = (pay_copy == copy_id_t'(2)) || (pay_copy == copy_id_t'(3));
		done_hit[0]   = (frame_id == copy_id_t'(1)) || (frame_id == copy_id_t'(2));
		done_hit[1]   = (frame_id == copy_id_t'(1)) || (frame_id == copy_id_t'(3));
		done_hit[2]   = (frame_id == copy_id_t'(2)) || (frame_id == copy_id_t'(3));
		other_byte[0] = (pay_copy == copy_id_t'(1)) ? cmp_rd_data2 : cmp_rd_data1;
		other_byte[1] = (pay_copy == copy_id_t'(1)) ? cmp_rd_data3 : cmp_rd_data1;
		other_byte[2] = (pay_copy == copy_id_t'(2)) ? cmp_rd_data3 : cmp_rd_data2;
		other_len[0]  = (frame_id == copy_id_t'(1)) ? copy_len2 : copy_len1;
		other_len[1]  = (frame_id == copy_id_t'(1)) ? copy_len3 : copy_len1;
		other_len[2]  = (frame_id == copy_id_t'(2)) ? copy_len3 : copy_len2;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			writing   <= 1'b0;
			agree     <= '0;
			copy_len1 <= '0;
			copy_len2 <= '0;
			copy_len3 <= '0;
		end else begin
			if (pay_wr_en)
				writing <= 1'b1;
			else if (frame_done)
				writing <= 1'b0; // next copy presets again
			for (int p = 0; p < 3; p++) begin
				if (pay_wr_en && wr_hit[p])
					agree[p] <= base[p] & (pay_byte == other_byte[p]);
				if (frame_done && done_hit[p])
					agree[p] <= base[p] & (frame_len == other_len[p]); // length check
			end
			if (frame_done && frame_id == copy_id_t'(1))
				copy_len1 <= frame_len;
			if (frame_done && frame_id == copy_id_t'(2))
				copy_len2 <= frame_len;
			if (frame_done && frame_id == copy_id_t'(3))
				copy_len3 <= frame_len;
		end
	end

endmodule

// ==== logic/copy_buffer.sv ====
`timescale 1ns/1ps
`include "redundant_rx_macros.svh"

module copy_buffer (
	input  logic                  clk,
	input  logic                  wr_en,
	input  logic [`RX_ADDR_W-1:0] wr_addr,
	input  logic [`RX_BYTE_W-1:0] wr_data,
	input  logic [`RX_ADDR_W-1:0] rd_addr_a,
	input  logic [`RX_ADDR_W-1:0] rd_addr_b,
	output logic [`RX_BYTE_W-1:0] rd_data_a,
	output logic [`RX_BYTE_W-1:0] rd_data_b
);

	localparam int depth = 1 << `RX_ADDR_W;

	logic [`RX_BYTE_W-1:0] mem [depth];

	// write port
	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// port a feeds the comparator, port b the replay
	always_ff @(posedge clk) begin
		rd_data_a <= mem[rd_addr_a]; // old data on a same-address write
		rd_data_b <= mem[rd_addr_b];
	end

endmodule

// ==== logic/frame_parser.sv ====
`timescale 1ns/1ps
`include "redundant_rx_macros.svh"

module frame_parser import redundant_rx_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     rx_en,
	input  rx_byte_t rx_data,
	output logic     pay_wr_en,
	output rx_addr_t pay_addr,
	output rx_byte_t pay_byte,
	output copy_id_t pay_copy,
	output rx_addr_t cmp_rd_addr,
	output logic     frame_done,
	output copy_id_t frame_id,
	output rx_addr_t frame_len
);

	localparam rx_addr_t id_offset = rx_addr_t'(`RX_ID_OFFSET);

	logic     rx_en_q; // registered strobe
	rx_byte_t rx_data_q; // registered byte
	logic     rx_en_d; // strobe one more cycle back, for the falling edge
	rx_addr_t off_cnt; // offset of the byte in rx_data_q
	rx_addr_t pay_cnt; // next payload address
	copy_id_t cur_id;
	logic     has_id; // id byte seen in this frame
	logic     is_payload;
	logic     frame_end;

	assign is_payload  = rx_en_q && (off_cnt > id_offset);
	assign frame_end   = rx_en_d && !rx_en_q;
	assign cmp_rd_addr = pay_cnt; // read ahead so data lines up with the write

	// ====================
	// control
	// ====================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_en_q    <= 1'b0;
			rx_en_d    <= 1'b0;
			off_cnt    <= '0;
			pay_cnt    <= '0;
			has_id     <= 1'b0;
			pay_wr_en  <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			rx_en_q    <= rx_en;
			rx_en_d    <= rx_en_q;
			off_cnt    <= rx_en_q ? off_cnt + 1'b1 : '0;
			pay_wr_en  <= is_payload;
			frame_done <= frame_end && has_id; // short frames are dropped here
			if (!rx_en_q)
				pay_cnt <= '0;
			else if (is_payload)
				pay_cnt <= pay_cnt + 1'b1;
			if (rx_en_q && off_cnt == id_offset)
				has_id <= 1'b1;
			else if (frame_end)
				has_id <= 1'b0;
		end
	end

	// ====================
	// payload path
	// ====================
	always_ff @(posedge clk) begin
		rx_data_q <= rx_data;
		pay_byte  <= rx_data_q;
		pay_addr  <= pay_cnt;
		pay_copy  <= cur_id;
		if (rx_en_q && off_cnt == id_offset)
			cur_id <= rx_data_q[3:0];
		if (frame_end) begin
			frame_id  <= cur_id;
			frame_len <= pay_cnt; // count of payload bytes written
		end
	end

endmodule

// ==== logic/redundant_rx_pkg.sv ====
`include "redundant_rx_macros.svh"

package redundant_rx_pkg;

	// ====================
	// data widths
	// ====================

	typedef logic [`RX_BYTE_W-1:0] rx_byte_t; // one stream byte
	typedef logic [`RX_ADDR_W-1:0] rx_addr_t; // payload address or length

	// ====================
	// copy bookkeeping
	// ====================

	typedef logic [3:0] copy_id_t; // low nibble of the id byte
	typedef logic [$clog2(`RX_COPIES + 1)-1:0] copy_sel_t; // copy 1..3, 0 unused

	// bit 0: 1/2, bit 1: 1/3, bit 2: 2/3
	typedef logic [`RX_COPIES*(`RX_COPIES-1)/2-1:0] pair_agree_t;

	// set tracking
	typedef enum logic [1:0] {
		st_idle, // waiting for copy 1
		st_got1, // copy 1 stored
		st_got2, // copies 1 and 2 stored
		st_vote // all three in, vote next cycle
	} set_state_e;

endpackage

// ==== logic/redundant_rx_macros.svh ====
`ifndef REDUNDANT_RX_MACROS_SVH
`define REDUNDANT_RX_MACROS_SVH

// ====================
// frame layout
// ====================

// byte offset of the copy id within a frame, low nibble holds the number
`define RX_ID_OFFSET 22

// ====================
// widths and counts
// ====================

`define RX_BYTE_W 8 // stream byte
`define RX_ADDR_W 12 // payload address and length
`define RX_COPIES 3 // redundant copies per set

`endif
